/* design/chunk_residue_stage.sv */
`default_nettype none

module chunk_residue_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_valid,
  input  mod503_pkg::operand_t        in_operand,
  input  mod503_pkg::tag_t            in_tag,
  output logic                        res_valid,
  output mod503_pkg::chunk_res_array_t res_chunks,
  output mod503_pkg::tag_t            res_tag
);

  import mod503_pkg::*;

  typedef logic [(1 << CHUNK_W)-1:0][RES_W-1:0] lut_t;

  // Residue of every chunk value times one position weight.
  function automatic lut_t build_lut(input int unsigned weight);
    lut_t lut;
    for (int unsigned v = 0; v < (1 << CHUNK_W); v++)
      lut[v] = RES_W'((v * weight) % MODULUS);
    return lut;
  endfunction

  chunk_res_array_t lut_out;

  for (genvar i = 0; i < NUM_CHUNKS; i++)
  begin : g_chunk
    localparam lut_t LUT = build_lut(chunk_weight(i));  // Fixed at elaboration.

    assign lut_out[i] = LUT[in_operand[CHUNK_W*i +: CHUNK_W]];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      res_valid <= 1'b0;
    else
      res_valid <= in_valid;
  end

  // Payload only moves with a valid operand.
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      res_chunks <= lut_out;
      res_tag <= in_tag;
    end
  end

endmodule

`default_nettype wire

/* design/credit_result_queue.sv */
`default_nettype none

module credit_result_queue (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fold_valid,
  input  mod503_pkg::residue_t  fold_residue,
  input  mod503_pkg::tag_t      fold_tag,
  input  logic                  out_credit,
  output logic                  out_valid,
  output mod503_pkg::residue_t  out_residue,
  output mod503_pkg::tag_t      out_tag,
  output logic                  in_credit
);

  import mod503_pkg::*;

  typedef logic [$clog2(QUEUE_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] count_t;
  typedef logic [$clog2(OUT_CREDITS+1)-1:0] credit_cnt_t;

  residue_t    res_mem [QUEUE_DEPTH];
  tag_t        tag_mem [QUEUE_DEPTH];
  ptr_t        wr_ptr;
  ptr_t        rd_ptr;
  count_t      count;
  credit_cnt_t credits;  // Downstream credits on hand.
  logic        pop;

  // Sender credits cover the pipeline and queue, so a push always fits.
  always_ff @(posedge clk)
  begin
    if (fold_valid)
    begin
      res_mem[wr_ptr] <= fold_residue;
      tag_mem[wr_ptr] <= fold_tag;
    end
  end

  assign pop = (count != '0) && (credits != '0);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (fold_valid)
        wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two.
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (fold_valid && !pop)
        count <= count + 1'b1;
      else if (!fold_valid && pop)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      credits <= credit_cnt_t'(OUT_CREDITS);
    else if (pop && !out_credit)
      credits <= credits - 1'b1;
    else if (!pop && out_credit)
      credits <= credits + 1'b1;
  end

  // Each send frees a queue slot, which goes back upstream.
  assign out_valid = pop;
  assign in_credit = pop;
  assign out_residue = res_mem[rd_ptr];
  assign out_tag = tag_mem[rd_ptr];

endmodule

`default_nettype wire

/* design/mod503_pkg.sv */
`default_nettype none

package mod503_pkg;

  localparam int OPERAND_W = 300;
  localparam int CHUNK_W = 6;
  localparam int NUM_CHUNKS = 50;
  localparam int RES_W = 9;
  localparam int MODULUS = 503;
  localparam int SUM_W = 15;  // Holds 50 * 502.
  localparam int TAG_W = 4;

  localparam int QUEUE_DEPTH = 8;  // Also the sender's credits after reset.
  localparam int OUT_CREDITS = 4;

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [RES_W-1:0] residue_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [SUM_W-1:0] sum_t;
  typedef logic [NUM_CHUNKS-1:0][RES_W-1:0] chunk_res_array_t;

  // Weight of chunk idx, 2^(6*idx) mod 503.
  function automatic int unsigned chunk_weight(input int unsigned idx);
    int unsigned w;
    w = 1;
    for (int unsigned i = 0; i < idx; i++)
      w = (w * (1 << CHUNK_W)) % MODULUS;
    return w;
  endfunction

endpackage

`default_nettype wire

/* design/mod503_reducer_top.sv */
`default_nettype none

module mod503_reducer_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  mod503_pkg::operand_t  in_operand,
  input  mod503_pkg::tag_t      in_tag,
  output logic                  in_credit,
  output logic                  out_valid,
  output mod503_pkg::residue_t  out_residue,
  output mod503_pkg::tag_t      out_tag,
  input  logic                  out_credit
);

  import mod503_pkg::*;

  logic             res_valid;
  chunk_res_array_t res_chunks;
  tag_t             res_tag;

  logic             sum_valid;
  sum_t             sum;
  tag_t             sum_tag;

  logic             fold_valid;
  residue_t         fold_residue;
  tag_t             fold_tag;

  // Three cycles from in_valid to queue entry.
  chunk_residue_stage u_chunk (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_operand (in_operand),
    .in_tag     (in_tag),
    .res_valid  (res_valid),
    .res_chunks (res_chunks),
    .res_tag    (res_tag)
  );

  residue_sum_tree u_sum (
    .clk        (clk),
    .rst        (rst),
    .res_valid  (res_valid),
    .res_chunks (res_chunks),
    .res_tag    (res_tag),
    .sum_valid  (sum_valid),
    .sum        (sum),
    .sum_tag    (sum_tag)
  );

  residue_fold u_fold (
    .clk          (clk),
    .rst          (rst),
    .sum_valid    (sum_valid),
    .sum          (sum),
    .sum_tag      (sum_tag),
    .fold_valid   (fold_valid),
    .fold_residue (fold_residue),
    .fold_tag     (fold_tag)
  );

  credit_result_queue u_queue (
    .clk          (clk),
    .rst          (rst),
    .fold_valid   (fold_valid),
    .fold_residue (fold_residue),
    .fold_tag     (fold_tag),
    .out_credit   (out_credit),
    .out_valid    (out_valid),
    .out_residue  (out_residue),
    .out_tag      (out_tag),
    .in_credit    (in_credit)
  );

endmodule

`default_nettype wire

/* design/residue_fold.sv */
`default_nettype none

module residue_fold (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sum_valid,
  input  mod503_pkg::sum_t      sum,
  input  mod503_pkg::tag_t      sum_tag,
  output logic                  fold_valid,
  output mod503_pkg::residue_t  fold_residue,
  output mod503_pkg::tag_t      fold_tag
);

  import mod503_pkg::*;

  logic [RES_W+1:0] fold1;  // At most 511 + 63 * 9.
  logic [RES_W:0]   fold2;  // At most 511 + 3 * 9.
  residue_t         fold_next;

  // 512 is 9 mod 503, so upper bits come back in at nine times their value.
  always_comb
  begin
    fold1 = (RES_W+2)'(sum[RES_W-1:0])
          + (RES_W+2)'(sum[SUM_W-1:RES_W]) * (RES_W+2)'(9);
    fold2 = (RES_W+1)'(fold1[RES_W-1:0])
          + (RES_W+1)'(fold1[RES_W+1:RES_W]) * (RES_W+1)'(9);
    // One subtraction is enough below 1006.
    if (fold2 >= (RES_W+1)'(MODULUS))
      fold_next = residue_t'(fold2 - (RES_W+1)'(MODULUS));
    else
      fold_next = residue_t'(fold2);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      fold_valid <= 1'b0;
    else
      fold_valid <= sum_valid;
  end

  always_ff @(posedge clk)
  begin
    if (sum_valid)
    begin
      fold_residue <= fold_next;
      fold_tag <= sum_tag;
    end
  end

endmodule

`default_nettype wire

/* design/residue_sum_tree.sv */
`default_nettype none

module residue_sum_tree (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        res_valid,
  input  mod503_pkg::chunk_res_array_t res_chunks,
  input  mod503_pkg::tag_t            res_tag,
  output logic                        sum_valid,
  output mod503_pkg::sum_t            sum,
  output mod503_pkg::tag_t            sum_tag
);

  import mod503_pkg::*;

  // Three-input adder tree, 50 -> 17 -> 6 -> 2 -> 1.
  sum_t lvl0 [51];
  sum_t lvl1 [18];
  sum_t lvl2 [6];
  sum_t lvl3 [3];
  sum_t total;

  always_comb
  begin
    lvl0[NUM_CHUNKS] = '0;  // Pad to a multiple of three.
    for (int i = 0; i < NUM_CHUNKS; i++)
      lvl0[i] = sum_t'(res_chunks[i]);
    lvl1[17] = '0;
    for (int i = 0; i < 17; i++)
      lvl1[i] = lvl0[3*i] + lvl0[3*i+1] + lvl0[3*i+2];
    for (int i = 0; i < 6; i++)
      lvl2[i] = lvl1[3*i] + lvl1[3*i+1] + lvl1[3*i+2];
    lvl3[2] = '0;
    for (int i = 0; i < 2; i++)
      lvl3[i] = lvl2[3*i] + lvl2[3*i+1] + lvl2[3*i+2];
    total = lvl3[0] + lvl3[1] + lvl3[2];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      sum_valid <= 1'b0;
    else
      sum_valid <= res_valid;
  end

  always_ff @(posedge clk)
  begin
    if (res_valid)
    begin
      sum <= total;
      sum_tag <= res_tag;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the mod-503 reducer testbench with Verilator.
set -e

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
LOG=sim.log
SIM=mod503_reducer_sim

rm -rf "$OBJ_DIR"
verilator --binary --timing --assert -Wno-fatal \
  --top-module mod503_reducer_tb \
  --Mdir "$OBJ_DIR" -o "$SIM" \
  -f sim.f

# A failing assertion stops the run early; the log decides the result.
"./$OBJ_DIR/$SIM" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^Testbench passed$" "$LOG"; then
  exit 0
else
  echo "run_sim: simulation did not pass, see $LOG"
  exit 1
fi

/* sim.f */
design/mod503_pkg.sv
design/chunk_residue_stage.sv
design/residue_sum_tree.sv
design/residue_fold.sv
design/credit_result_queue.sv
design/mod503_reducer_top.sv
verif/credit_result_queue_chk.sv
verif/mod503_reducer_tb.sv

/* verif/credit_result_queue_chk.sv */
`default_nettype none

module credit_result_queue_chk (
  input logic                                          clk,
  input logic                                          rst,
  input logic                                          fold_valid,
  input logic                                          out_valid,
  input logic                                          out_credit,
  input mod503_pkg::residue_t                          out_residue,
  input logic [$clog2(mod503_pkg::QUEUE_DEPTH+1)-1:0]  count
);

  import mod503_pkg::*;

  int sends_open;  // Sends not yet matched by a returned credit.

  always_ff @(posedge clk)
  begin
    if (rst)
      sends_open <= 0;
    else
      sends_open <= sends_open + int'(out_valid) - int'(out_credit);
  end

  // A send spends one downstream credit.
  send_needs_credit: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> sends_open < OUT_CREDITS)
    else $error("out_valid with zero downstream credits");

  count_in_range: assert property (@(posedge clk) disable iff (rst)
    count <= QUEUE_DEPTH)
    else $error("queue count above depth");

  // Push into a full queue without a pop in the same cycle.
  no_overflow: assert property (@(posedge clk) disable iff (rst)
    (fold_valid && !out_valid) |-> count < QUEUE_DEPTH)
    else $error("queue overflow");

  residue_below_modulus: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> out_residue < residue_t'(MODULUS))
    else $error("out_residue not below modulus");

endmodule

bind credit_result_queue credit_result_queue_chk u_chk (
  .clk         (clk),
  .rst         (rst),
  .fold_valid  (fold_valid),
  .out_valid   (out_valid),
  .out_credit  (out_credit),
  .out_residue (out_residue),
  .count       (count)
);

`default_nettype wire

/* verif/mod503_reducer_tb.sv */
`default_nettype none

module mod503_reducer_tb;

  import mod503_pkg::*;

  localparam int SEED = 47472;
  localparam int CLK_PERIOD = 10;
  localparam int NUM_RANDOM = 200;
  localparam int NUM_EDGE = 4;
  localparam int NUM_GAPPED = 40;
  localparam int NUM_HOLD = QUEUE_DEPTH;
  localparam int NUM_RESET = QUEUE_DEPTH / 2 + QUEUE_DEPTH;
  localparam int TOTAL_OPS = NUM_RANDOM + NUM_EDGE + NUM_GAPPED + NUM_HOLD + NUM_RESET;
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * 40 + 400;

  logic     clk;
  logic     rst;
  logic     in_valid;
  operand_t in_operand;
  tag_t     in_tag;
  logic     in_credit;
  logic     out_valid;
  residue_t out_residue;
  tag_t     out_tag;
  logic     out_credit;

  residue_t    exp_res_q [$];  // Results sent but not yet delivered.
  tag_t        exp_tag_q [$];
  int          sender_credits;
  int          recv_owed;      // Credits the receiver still has to return.
  int          deliveries;
  int          error_count;
  int          check_count;
  int          tests_run;
  int          tests_failed;
  int          test_start_errors;
  bit          hold_credits;

  mod503_reducer_top uut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_operand  (in_operand),
    .in_tag      (in_tag),
    .in_credit   (in_credit),
    .out_valid   (out_valid),
    .out_residue (out_residue),
    .out_tag     (out_tag),
    .out_credit  (out_credit)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles with results still missing", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  // Horner reduction from the top chunk down.
  function automatic residue_t ref_residue(input operand_t op);
    int r;
    r = 0;
    for (int i = NUM_CHUNKS - 1; i >= 0; i--)
      r = (r * (1 << CHUNK_W) + int'(op[CHUNK_W*i +: CHUNK_W])) % MODULUS;
    return residue_t'(r);
  endfunction

  function automatic operand_t rand_operand();
    operand_t op;
    op = '0;
    for (int i = 0; i < (OPERAND_W + 31) / 32; i++)
      op = (op << 32) | operand_t'($urandom);
    return op;
  endfunction

  task automatic flag_error(input string msg);
    error_count++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic compare_residue(input string name, input residue_t expected,
                                 input residue_t actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_tag(input string name, input tag_t expected, input tag_t actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Outputs only depend on registers, so the falling edge sees what the next rise takes.
  task automatic advance();
    @(negedge clk);
    if (out_valid)
    begin
      if (exp_res_q.size() == 0)
        flag_error("out_valid with no result outstanding");
      else
      begin
        compare_residue("out_residue", exp_res_q.pop_front(), out_residue);
        compare_tag("out_tag", exp_tag_q.pop_front(), out_tag);
      end
      deliveries++;
      recv_owed++;
    end
    if (in_credit !== out_valid)
      flag_error("in_credit did not follow out_valid");
    if (in_credit)
      sender_credits++;
    if (sender_credits + exp_res_q.size() != QUEUE_DEPTH)
      flag_error($sformatf("credit balance off, sender holds %0d with %0d outstanding",
                           sender_credits, exp_res_q.size()));
    in_valid = 1'b0;
    if (!hold_credits && recv_owed > 0 && ($urandom % 3) == 0)
    begin
      out_credit = 1'b1;  // Random gaps between returns.
      recv_owed--;
    end
    else
      out_credit = 1'b0;
  endtask

  task automatic send_operand(input operand_t op, input tag_t tg, input residue_t expected);
    advance();
    while (sender_credits == 0)
      advance();
    in_valid = 1'b1;
    in_operand = op;
    in_tag = tg;
    exp_res_q.push_back(expected);
    exp_tag_q.push_back(tg);
    sender_credits--;
  endtask

  task automatic drain();
    hold_credits = 1'b0;
    advance();
    while (exp_res_q.size() != 0 || recv_owed != 0)
      advance();
    advance();  // Last out_credit lands.
    if (sender_credits != QUEUE_DEPTH)
      flag_error($sformatf("sender ended with %0d credits instead of %0d",
                           sender_credits, QUEUE_DEPTH));
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    in_valid = 1'b0;
    out_credit = 1'b0;
    hold_credits = 1'b0;
    exp_res_q.delete();
    exp_tag_q.delete();
    sender_credits = QUEUE_DEPTH;
    recv_owed = 0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic start_test();
    test_start_errors = error_count;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count == test_start_errors)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, error_count - test_start_errors);
    end
  endtask

  task automatic check_held_release(input int num_ops);
    int start;
    operand_t op;
    start = deliveries;
    hold_credits = 1'b1;
    for (int i = 0; i < num_ops; i++)
    begin
      op = rand_operand();
      send_operand(op, tag_t'(i), ref_residue(op));
    end
    repeat (QUEUE_DEPTH + 8) advance();
    if (deliveries - start != OUT_CREDITS)
      flag_error($sformatf("%0d results sent while credits were held, expected %0d",
                           deliveries - start, OUT_CREDITS));
    drain();
  endtask

  initial
  begin
    operand_t op;
    rst = 1'b1;
    in_valid = 1'b0;
    in_operand = '0;
    in_tag = '0;
    out_credit = 1'b0;
    hold_credits = 1'b0;
    sender_credits = QUEUE_DEPTH;
    recv_owed = 0;
    deliveries = 0;
    error_count = 0;
    check_count = 0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(SEED));
    apply_reset();

    start_test();
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      op = rand_operand();
      send_operand(op, tag_t'($urandom), ref_residue(op));
    end
    drain();
    finish_test("random operands");

    start_test();
    send_operand('0, tag_t'(1), residue_t'(0));
    send_operand('1, tag_t'(2), ref_residue('1));
    send_operand(operand_t'(MODULUS) * operand_t'($urandom_range(1, 1000)), tag_t'(3),
                 residue_t'(0));
    send_operand(operand_t'(MODULUS - 1), tag_t'(4), residue_t'(MODULUS - 1));
    drain();
    finish_test("edge operands");

    start_test();
    check_held_release(NUM_HOLD);
    finish_test("withheld output credits");

    start_test();
    for (int i = 0; i < NUM_GAPPED; i++)
    begin
      repeat ($urandom_range(0, 5)) advance();
      op = rand_operand();
      send_operand(op, tag_t'($urandom), ref_residue(op));
    end
    drain();
    finish_test("credit balance");

    start_test();
    hold_credits = 1'b1;
    for (int i = 0; i < QUEUE_DEPTH / 2; i++)
    begin
      op = rand_operand();
      send_operand(op, tag_t'(i), ref_residue(op));
    end
    repeat (2) advance();
    apply_reset();  // Drops results in flight.
    repeat (10)
    begin
      advance();
      if (out_valid || in_credit)
        flag_error("output active after reset with no new input");
    end
    check_held_release(QUEUE_DEPTH);
    finish_test("mid-run reset");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0 && tests_failed == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
